/* hdl/decompose_pkg.sv */
//**********************************************************************
// Constants and controller state for the ML-DSA-87 decompose unit.
// A memory word carries NUM_LANES coefficients in REG_SIZE-bit slots,
// the top bit of every slot is expected to be zero.
//**********************************************************************

package decompose_pkg;

    // ML-DSA-87 arithmetic
    localparam logic [23:0] MLDSA_Q      = 24'd8380417;
    localparam int unsigned MLDSA_GAMMA2 = 261888;
    localparam int unsigned TWO_GAMMA2   = 523776;

    // Coefficient and memory geometry
    localparam int unsigned COEFF_WIDTH    = 23;
    localparam int unsigned REG_SIZE       = 24;
    localparam int unsigned NUM_LANES      = 4;
    localparam int unsigned MEM_DATA_WIDTH = 96;
    localparam int unsigned ADDR_WIDTH     = 14;
    localparam int unsigned NUM_WORDS      = 64;
    localparam int unsigned IDX_WIDTH      = $clog2(NUM_WORDS);

    // High bits and their packed form
    localparam int unsigned R1_WIDTH  = 4;
    localparam int unsigned W1_WIDTH  = 64;
    localparam int unsigned W1_GROUPS = 4;

    // Sequencer states
    typedef enum logic [1:0] {
        DCMP_IDLE,
        DCMP_READ,
        DCMP_DRAIN
    } dcmp_state_e;

endpackage

/* hdl/decompose_ctrl.sv */
//**********************************************************************
// Read sequencer for one polynomial of NUM_WORDS memory words.
// Read data must arrive one cycle after the read strobe. start_i is
// ignored unless the FSM is idle; there is no back-pressure.
//**********************************************************************
`timescale 1ns/100ps

module decompose_ctrl
    import decompose_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  start_i,
    input  logic [ADDR_WIDTH-1:0] src_base_addr_i,
    output logic                  mem_rd_en_o,
    output logic [ADDR_WIDTH-1:0] mem_rd_addr_o,
    output logic                  lane_en_o,
    output logic                  wr_valid_o,
    output logic [IDX_WIDTH-1:0]  wr_index_o,
    output logic                  done_o
);

    dcmp_state_e          state;
    logic [IDX_WIDTH-1:0] word_cnt;
    logic [IDX_WIDTH-1:0] lane_index;
    logic                 out_valid_q;
    logic                 drain_done;

    // Last write sits in the output stage and nothing is behind it
    assign drain_done = (state == DCMP_DRAIN) && out_valid_q && !wr_valid_o && !lane_en_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= DCMP_IDLE;
            word_cnt      <= '0;
            mem_rd_en_o   <= 1'b0;
            mem_rd_addr_o <= '0;
            done_o        <= 1'b0;
        end else if (zeroize_i) begin
            state         <= DCMP_IDLE;
            word_cnt      <= '0;
            mem_rd_en_o   <= 1'b0;
            mem_rd_addr_o <= '0;
            done_o        <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                DCMP_IDLE: begin
                    if (start_i) begin
                        state         <= DCMP_READ;
                        word_cnt      <= '0;
                        mem_rd_en_o   <= 1'b1;
                        mem_rd_addr_o <= src_base_addr_i;
                    end
                end
                DCMP_READ: begin
                    if (word_cnt == IDX_WIDTH'(NUM_WORDS - 1)) begin
                        state       <= DCMP_DRAIN;
                        mem_rd_en_o <= 1'b0;
                    end else begin
                        word_cnt      <= word_cnt + 1'b1;
                        mem_rd_addr_o <= mem_rd_addr_o + 1'b1;
                    end
                end
                DCMP_DRAIN: begin
                    if (drain_done) begin
                        state  <= DCMP_IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= DCMP_IDLE;
            endcase
        end
    end

    // Valid and word index follow each read through memory and lane stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_en_o   <= 1'b0;
            lane_index  <= '0;
            wr_valid_o  <= 1'b0;
            wr_index_o  <= '0;
            out_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            lane_en_o   <= 1'b0;
            lane_index  <= '0;
            wr_valid_o  <= 1'b0;
            wr_index_o  <= '0;
            out_valid_q <= 1'b0;
        end else begin
            lane_en_o   <= mem_rd_en_o;
            lane_index  <= word_cnt;
            wr_valid_o  <= lane_en_o;
            wr_index_o  <= lane_index;
            out_valid_q <= wr_valid_o;
        end
    end

endmodule

/* hdl/decompose_lane.sv */
//**********************************************************************
// One decompose lane: r = r1*2*GAMMA2 + r0 with r0 in (-GAMMA2, GAMMA2]
// and r0 kept modulo q. Input must already be below q.
// When r - r0 = q - 1, r1 becomes 0 and r0 is reduced by one.
//**********************************************************************
`timescale 1ns/100ps

module decompose_lane
    import decompose_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   lane_en_i,
    input  logic [COEFF_WIDTH-1:0] r_i,
    output logic [COEFF_WIDTH-1:0] r0_o,
    output logic [R1_WIDTH-1:0]    r1_o,
    output logic                   r1_nez_o
);

    logic [R1_WIDTH:0]      r1_cnt;
    logic [COEFF_WIDTH+1:0] r1_prod;
    logic [COEFF_WIDTH+1:0] r0_diff;
    logic [COEFF_WIDTH-1:0] r0_mod_q;
    logic [COEFF_WIDTH-1:0] r0_q;
    logic                   corner_q;

    // r1 is the number of odd multiples of GAMMA2 lying below r
    always_comb begin
        r1_cnt = '0;
        for (int k = 1; k <= 2 ** R1_WIDTH; k++) begin
            if ({1'b0, r_i} > 24'((2 * k - 1) * MLDSA_GAMMA2)) begin
                r1_cnt = r1_cnt + 1'b1;
            end
        end
    end

    // Centered remainder, negative values wrap to r0 + q
    always_comb begin
        r1_prod  = (COEFF_WIDTH + 2)'(r1_cnt) * (COEFF_WIDTH + 2)'(TWO_GAMMA2);
        r0_diff  = {2'b00, r_i} - r1_prod;
        r0_mod_q = r0_diff[COEFF_WIDTH+1] ? COEFF_WIDTH'(r0_diff + (COEFF_WIDTH + 2)'(MLDSA_Q))
                                          : r0_diff[COEFF_WIDTH-1:0];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r0_q     <= '0;
            r1_o     <= '0;
            r1_nez_o <= 1'b0;
            corner_q <= 1'b0;
        end else if (zeroize_i) begin
            r0_q     <= '0;
            r1_o     <= '0;
            r1_nez_o <= 1'b0;
            corner_q <= 1'b0;
        end else if (lane_en_i) begin
            r0_q     <= r0_mod_q;
            // r1 = 16 wraps to 0 in the low bits
            r1_o     <= r1_cnt[R1_WIDTH-1:0];
            r1_nez_o <= |r1_cnt[R1_WIDTH-1:0];
            corner_q <= r1_cnt[R1_WIDTH];
        end
    end

    // Corner case: take one off r0 modulo q, which gives back r
    always_comb begin
        if (!corner_q) begin
            r0_o = r0_q;
        end else if (r0_q == '0) begin
            r0_o = COEFF_WIDTH'(MLDSA_Q - 1'b1);
        end else begin
            r0_o = r0_q - 1'b1;
        end
    end

endmodule

/* hdl/decompose_w1_encode.sv */
//**********************************************************************
// Packs r1 values into w1 words, W1_GROUPS memory words per w1 word.
// Group 0 lands in the low bits, lane 0 in the low nibble of a group.
// w1_o holds its value between valid pulses.
//**********************************************************************
`timescale 1ns/100ps

module decompose_w1_encode
    import decompose_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  logic                               group_valid_i,
    input  logic [NUM_LANES-1:0][R1_WIDTH-1:0] r1_i,
    output logic [W1_WIDTH-1:0]                w1_o,
    output logic                               w1_valid_o
);

    localparam int unsigned GRP_BITS = NUM_LANES * R1_WIDTH;
    localparam int unsigned CNT_BITS = $clog2(W1_GROUPS);

    logic [CNT_BITS-1:0] grp_cnt;
    logic [W1_WIDTH-1:0] shift_q;
    logic [GRP_BITS-1:0] group;
    logic                last_group;

    assign group      = r1_i;
    assign last_group = group_valid_i && (grp_cnt == CNT_BITS'(W1_GROUPS - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grp_cnt    <= '0;
            shift_q    <= '0;
            w1_o       <= '0;
            w1_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            grp_cnt    <= '0;
            shift_q    <= '0;
            w1_o       <= '0;
            w1_valid_o <= 1'b0;
        end else begin
            w1_valid_o <= last_group;
            if (group_valid_i) begin
                // New groups enter at the top and move down
                shift_q <= {group, shift_q[W1_WIDTH-1:GRP_BITS]};
                grp_cnt <= grp_cnt + 1'b1;
            end
            if (last_group) begin
                w1_o <= {group, shift_q[W1_WIDTH-1:GRP_BITS]};
            end
        end
    end

endmodule

/* hdl/decompose_top.sv */
//**********************************************************************
// ML-DSA-87 decompose unit for one polynomial per start pulse.
// Memory sits outside and must answer a read in the next cycle and
// accept a write every cycle. Writes come 3 cycles after their reads.
//**********************************************************************
`timescale 1ns/100ps

module decompose_top
    import decompose_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      start_i,
    input  logic [ADDR_WIDTH-1:0]     src_base_addr_i,
    input  logic [ADDR_WIDTH-1:0]     dest_base_addr_i,
    input  logic [MEM_DATA_WIDTH-1:0] mem_rd_data_i,
    output logic                      mem_rd_en_o,
    output logic [ADDR_WIDTH-1:0]     mem_rd_addr_o,
    output logic                      mem_wr_en_o,
    output logic [ADDR_WIDTH-1:0]     mem_wr_addr_o,
    output logic [MEM_DATA_WIDTH-1:0] mem_wr_data_o,
    output logic                      z_wr_en_o,
    output logic [ADDR_WIDTH-1:0]     z_wr_addr_o,
    output logic [NUM_LANES-1:0]      z_neq_z_o,
    output logic [W1_WIDTH-1:0]       w1_o,
    output logic                      w1_valid_o,
    output logic                      done_o
);

    logic                               lane_en;
    logic                               wr_valid;
    logic [IDX_WIDTH-1:0]               wr_index;
    logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] r0;
    logic [NUM_LANES-1:0][R1_WIDTH-1:0]    r1;
    logic [NUM_LANES-1:0][R1_WIDTH-1:0]    r1_q;
    logic [NUM_LANES-1:0]               r1_nez;
    logic [MEM_DATA_WIDTH-1:0]          wr_data;
    logic [ADDR_WIDTH-1:0]              dest_base_q;
    logic                               run_active;

    decompose_ctrl ctrl_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .start_i         (start_i),
        .src_base_addr_i (src_base_addr_i),
        .mem_rd_en_o     (mem_rd_en_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .lane_en_o       (lane_en),
        .wr_valid_o      (wr_valid),
        .wr_index_o      (wr_index),
        .done_o          (done_o)
    );

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            decompose_lane lane_inst (
                .clk       (clk),
                .reset_n   (reset_n),
                .zeroize_i (zeroize_i),
                .lane_en_i (lane_en),
                .r_i       (mem_rd_data_i[i*REG_SIZE +: COEFF_WIDTH]),
                .r0_o      (r0[i]),
                .r1_o      (r1[i]),
                .r1_nez_o  (r1_nez[i])
            );
            // Zero-extend each r0 into its memory slot
            assign wr_data[i*REG_SIZE +: REG_SIZE] = {1'b0, r0[i]};
        end
    endgenerate

    // Busy from the first read until the last write, same window as the FSM
    assign run_active = mem_rd_en_o | lane_en | wr_valid | mem_wr_en_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dest_base_q   <= '0;
            mem_wr_en_o   <= 1'b0;
            mem_wr_addr_o <= '0;
            mem_wr_data_o <= '0;
            z_wr_en_o     <= 1'b0;
            z_wr_addr_o   <= '0;
            z_neq_z_o     <= '0;
            r1_q          <= '0;
        end else if (zeroize_i) begin
            dest_base_q   <= '0;
            mem_wr_en_o   <= 1'b0;
            mem_wr_addr_o <= '0;
            mem_wr_data_o <= '0;
            z_wr_en_o     <= 1'b0;
            z_wr_addr_o   <= '0;
            z_neq_z_o     <= '0;
            r1_q          <= '0;
        end else begin
            if (start_i && !run_active) begin
                dest_base_q <= dest_base_addr_i;
            end
            mem_wr_en_o <= wr_valid;
            z_wr_en_o   <= wr_valid;
            if (wr_valid) begin
                mem_wr_addr_o <= dest_base_q + ADDR_WIDTH'(wr_index);
                mem_wr_data_o <= wr_data;
                // Flag buffer is addressed by word index only
                z_wr_addr_o   <= ADDR_WIDTH'(wr_index);
                z_neq_z_o     <= r1_nez;
                r1_q          <= r1;
            end
        end
    end

    // Packer sees each group together with its memory write
    decompose_w1_encode w1_enc_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .group_valid_i (mem_wr_en_o),
        .r1_i          (r1_q),
        .w1_o          (w1_o),
        .w1_valid_o    (w1_valid_o)
    );

endmodule

/* testbench/decompose_model.svh */
//**********************************************************************
// Reference decompose for the testbench, computed as a centered
// remainder modulo 2*GAMMA2. Inputs must be below q.
// Also packs four coefficients into one 96-bit memory word.
//**********************************************************************
`ifndef DECOMPOSE_MODEL_SVH
`define DECOMPOSE_MODEL_SVH

function automatic void decompose_ref(input int unsigned r, output int unsigned r0,
                                      output int unsigned r1);
    int rem;
    int hi;
    rem = int'(r % TWO_GAMMA2);
    // Centered remainder in (-GAMMA2, GAMMA2]
    if (rem > int'(MLDSA_GAMMA2)) begin
        rem = rem - int'(TWO_GAMMA2);
    end
    hi = int'(r) - rem;
    if (hi == int'(MLDSA_Q) - 1) begin
        r1  = 0;
        rem = rem - 1;
    end else begin
        r1 = int'(hi / int'(TWO_GAMMA2));
    end
    if (rem < 0) begin
        rem = rem + int'(MLDSA_Q);
    end
    r0 = rem;
endfunction

function automatic logic [MEM_DATA_WIDTH-1:0] pack_coeffs(input logic [COEFF_WIDTH-1:0] c0,
    input logic [COEFF_WIDTH-1:0] c1, input logic [COEFF_WIDTH-1:0] c2,
    input logic [COEFF_WIDTH-1:0] c3);
    return {1'b0, c3, 1'b0, c2, 1'b0, c1, 1'b0, c0};
endfunction

`endif

/* testbench/decompose_tb.sv */
//**********************************************************************
// Testbench for decompose_top with a one-cycle-latency memory model.
// Every check runs at the falling edge, where inputs are also driven.
// Runs a full polynomial, one zeroized mid-run and another full one.
//**********************************************************************
`timescale 1ns/100ps

module decompose_tb
    import decompose_pkg::*;
();

    `include "decompose_model.svh"

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize_i;
    logic                      start_i;
    logic [ADDR_WIDTH-1:0]     src_base_addr_i;
    logic [ADDR_WIDTH-1:0]     dest_base_addr_i;
    logic [MEM_DATA_WIDTH-1:0] mem_rd_data_i;
    logic                      mem_rd_en_o;
    logic [ADDR_WIDTH-1:0]     mem_rd_addr_o;
    logic                      mem_wr_en_o;
    logic [ADDR_WIDTH-1:0]     mem_wr_addr_o;
    logic [MEM_DATA_WIDTH-1:0] mem_wr_data_o;
    logic                      z_wr_en_o;
    logic [ADDR_WIDTH-1:0]     z_wr_addr_o;
    logic [NUM_LANES-1:0]      z_neq_z_o;
    logic [W1_WIDTH-1:0]       w1_o;
    logic                      w1_valid_o;
    logic                      done_o;

    logic [MEM_DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH) - 1];
    integer                    seed;
    int                        cyc;
    int                        rd_cnt;
    int                        wr_cnt;
    int                        w1_cnt;
    int                        done_cnt;
    int                        last_wr_cyc;
    int                        rd_cyc [NUM_WORDS];
    logic [W1_WIDTH-1:0]       w1_acc;
    logic [W1_WIDTH-1:0]       w1_ready;
    logic                      pend_valid;
    logic [ADDR_WIDTH-1:0]     pend_addr;
    logic [ADDR_WIDTH-1:0]     src_q;
    logic [ADDR_WIDTH-1:0]     dest_q;
    logic                      quiet;

    decompose_top decompose_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%0t %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [MEM_DATA_WIDTH-1:0] exp,
                               input logic [MEM_DATA_WIDTH-1:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Check outputs and let memory answer last cycle's read
    task automatic step();
        logic [MEM_DATA_WIDTH-1:0] src_word;
        logic [MEM_DATA_WIDTH-1:0] exp_word;
        logic [NUM_LANES-1:0]      exp_nez;
        logic                      exp_wr;
        int unsigned               r0;
        int unsigned               r1;
        @(negedge clk);
        cyc++;
        if (quiet) begin
            check_value("mem_rd_en_o", '0, mem_rd_en_o);
            check_value("w1_valid_o", '0, w1_valid_o);
            check_value("done_o", '0, done_o);
        end
        // A write is due three cycles after each read
        exp_wr = !quiet && (wr_cnt < rd_cnt) && (rd_cyc[wr_cnt] + 3 == cyc);
        check_value("mem_wr_en_o", exp_wr, mem_wr_en_o);
        check_value("z_wr_en_o", exp_wr, z_wr_en_o);
        if (mem_rd_en_o) begin
            assert (rd_cnt < NUM_WORDS) else fail_now("more than 64 reads in one run");
            check_value("mem_rd_addr_o", src_q + rd_cnt, mem_rd_addr_o);
            rd_cyc[rd_cnt] = cyc;
            rd_cnt++;
        end
        if (w1_valid_o) begin
            assert (wr_cnt > 0 && wr_cnt % W1_GROUPS == 0) else
                fail_now("w1_valid_o without four new groups");
            check_value("w1_valid_o cycle", last_wr_cyc + 1, cyc);
            check_value("w1_o", w1_ready, w1_o);
            w1_cnt++;
        end
        if (done_o) begin
            done_cnt++;
            check_value("done_o cycle", last_wr_cyc + 1, cyc);
            check_value("writes before done_o", NUM_WORDS, wr_cnt);
        end
        if (exp_wr) begin
            check_value("mem_wr_addr_o", dest_q + wr_cnt, mem_wr_addr_o);
            check_value("z_wr_addr_o", wr_cnt, z_wr_addr_o);
            src_word = mem[src_q + wr_cnt];
            for (int l = 0; l < NUM_LANES; l++) begin
                decompose_ref(src_word[l*REG_SIZE +: COEFF_WIDTH], r0, r1);
                exp_word[l*REG_SIZE +: REG_SIZE] = REG_SIZE'(r0);
                exp_nez[l] = (r1 != 0);
                w1_acc[(wr_cnt % W1_GROUPS) * 16 + l * R1_WIDTH +: R1_WIDTH] = R1_WIDTH'(r1);
            end
            check_value("mem_wr_data_o", exp_word, mem_wr_data_o);
            check_value("z_neq_z_o", exp_nez, z_neq_z_o);
            if (wr_cnt % W1_GROUPS == W1_GROUPS - 1) begin
                w1_ready = w1_acc;
            end
            last_wr_cyc = cyc;
            wr_cnt++;
        end
        if (pend_valid) begin
            mem_rd_data_i = mem[pend_addr];
        end
        pend_valid = mem_rd_en_o;
        pend_addr  = mem_rd_addr_o;
    endtask

    task automatic fill_source(input logic [ADDR_WIDTH-1:0] base);
        logic [COEFF_WIDTH-1:0] c [NUM_LANES];
        for (int w = 0; w < NUM_WORDS; w++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                c[l] = COEFF_WIDTH'($unsigned($random(seed)) % MLDSA_Q);
            end
            // Edge values and values around 31*GAMMA2 in the first two words
            if (w == 0) begin
                c = '{23'd0, 23'(MLDSA_Q - 1), 23'(MLDSA_GAMMA2), 23'(MLDSA_GAMMA2 + 1)};
            end else if (w == 1) begin
                c = '{23'(31 * MLDSA_GAMMA2 - 1), 23'(31 * MLDSA_GAMMA2),
                      23'(31 * MLDSA_GAMMA2 + 1), 23'(MLDSA_Q - 2)};
            end
            mem[base + w] = pack_coeffs(c[0], c[1], c[2], c[3]);
        end
    endtask

    task automatic begin_run(input logic [ADDR_WIDTH-1:0] src,
                             input logic [ADDR_WIDTH-1:0] dest);
        src_q    = src;
        dest_q   = dest;
        rd_cnt   = 0;
        wr_cnt   = 0;
        w1_cnt   = 0;
        done_cnt = 0;
        w1_acc   = '0;
        fill_source(src);
        src_base_addr_i  = src;
        dest_base_addr_i = dest;
        start_i          = 1'b1;
        step();
        start_i = 1'b0;
    endtask

    task automatic run_full(input logic [ADDR_WIDTH-1:0] src,
                            input logic [ADDR_WIDTH-1:0] dest);
        int waited;
        begin_run(src, dest);
        waited = 0;
        while (done_cnt == 0) begin
            assert (waited < 200) else fail_now("timeout waiting for done_o");
            step();
            waited++;
        end
        // One more cycle shows that done_o was a single pulse
        step();
        check_value("read count", NUM_WORDS, rd_cnt);
        check_value("write count", NUM_WORDS, wr_cnt);
        check_value("w1_valid_o count", NUM_WORDS / W1_GROUPS, w1_cnt);
        check_value("done_o count", 1, done_cnt);
    endtask

    task automatic run_zeroized(input logic [ADDR_WIDTH-1:0] src,
                                input logic [ADDR_WIDTH-1:0] dest, input int cycles);
        begin_run(src, dest);
        repeat (cycles) step();
        zeroize_i = 1'b1;
        quiet     = 1'b1;
        step();
        zeroize_i = 1'b0;
        check_value("mem_wr_data_o", '0, mem_wr_data_o);
        check_value("z_neq_z_o", '0, z_neq_z_o);
        check_value("w1_o", '0, w1_o);
        // Nothing may be written after the clear
        repeat (12) step();
        quiet = 1'b0;
    endtask

    initial begin
        seed             = 32'h8b29;
        reset_n          = 1'b0;
        zeroize_i        = 1'b0;
        start_i          = 1'b0;
        src_base_addr_i  = '0;
        dest_base_addr_i = '0;
        mem_rd_data_i    = '0;
        pend_valid       = 1'b0;
        pend_addr        = '0;
        quiet            = 1'b1;
        cyc              = 0;
        last_wr_cyc      = 0;
        repeat (8) step();
        reset_n = 1'b1;
        step();
        quiet = 1'b0;
        run_full(14'h0000, 14'h0100);
        run_zeroized(14'h0400, 14'h0500, 30);
        run_full(14'h2000, 14'h3000);
        $display("Test OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
hdl/decompose_pkg.sv
hdl/decompose_ctrl.sv
hdl/decompose_lane.sv
hdl/decompose_w1_encode.sv
hdl/decompose_top.sv
testbench/decompose_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decompose testbench with Verilator.
# Exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module decompose_tb -o sim_decompose
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_decompose
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
